// File: Makefile
# Verilator flow for the host bridge

VERILATOR   ?= verilator
TOP         ?= host_bridge_tb
RTL_TOP     ?= host_bridge_top
FILELIST    ?= list.f
OBJ_DIR     ?= obj_dir
VFLAGS      ?= --timing --assert -j 0
PASS_STRING ?= >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_STRING)'

clean:
	rm -rf $(OBJ_DIR)

// File: list.f
src/mesh_pkg.sv
src/host_pkg.sv
src/word_deserializer.sv
src/word_serializer.sv
src/out_credit_counter.sv
src/inbound_txn_fsm.sv
src/host_bridge_top.sv
test/host_bridge_checker.sv
test/host_bridge_tb.sv

// File: src/host_bridge_top.sv
// Tile host bridge; no routing, one credit counter, and no buffering past the serializer registers
`timescale 1ns/10ps
`default_nettype none

module host_bridge_top (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic [mesh_pkg::x_cord_width-1:0]    my_x_i,
  input  logic [mesh_pkg::y_cord_width-1:0]    my_y_i,
  // Host words
  input  logic [host_pkg::host_word_width-1:0] host_req_word_i,
  input  logic                                host_req_valid_i,
  output logic                                host_req_ready_o,
  output logic [host_pkg::host_word_width-1:0] host_rsp_word_o,
  output logic                                host_rsp_valid_o,
  input  logic                                host_rsp_ready_i,
  output logic [host_pkg::host_word_width-1:0] host_in_req_word_o,
  output logic                                host_in_req_valid_o,
  input  logic                                host_in_req_ready_i,
  input  logic [host_pkg::host_word_width-1:0] host_in_rsp_word_i,
  input  logic                                host_in_rsp_valid_i,
  output logic                                host_in_rsp_ready_o,
  // Mesh packets
  output mesh_pkg::mesh_req_s                 net_out_o,
  output logic                                net_out_valid_o,
  input  logic                                net_out_ready_i,
  input  mesh_pkg::mesh_ret_s                 net_ret_i,
  input  logic                                net_ret_valid_i,
  output logic                                net_ret_ready_o,
  input  mesh_pkg::mesh_req_s                 net_in_i,
  input  logic                                net_in_valid_i,
  output logic                                net_in_ready_o,
  output mesh_pkg::mesh_ret_s                 net_ack_o,
  output logic                                net_ack_valid_o,
  input  logic                                net_ack_ready_i,
  output logic [mesh_pkg::credit_width-1:0]    credits_used_o
);

  host_pkg::aligned_req_s out_aligned;
  logic out_pkt_valid;
  logic out_pkt_ready;
  logic has_credit;
  host_pkg::aligned_rsp_s ret_aligned;
  mesh_pkg::mesh_req_s in_req;
  host_pkg::aligned_req_s in_aligned;
  logic in_pkt_valid;
  logic in_pkt_ready;
  host_pkg::aligned_req_s rd_aligned;
  logic [mesh_pkg::data_width-1:0] rd_data;
  logic rd_pkt_valid;
  logic rd_pkt_ready;

  // ------------------------------
  // Outbound request
  // ------------------------------
  word_deserializer u_out_deser (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .word_i       (host_req_word_i),
    .word_valid_i (host_req_valid_i),
    .word_ready_o (host_req_ready_o),
    .pkt_o        (out_aligned),
    .pkt_valid_o  (out_pkt_valid),
    .pkt_ready_i  (out_pkt_ready)
  );

  // Narrow to mesh widths, source is always this tile
  assign net_out_o.x_cord     = out_aligned.x_cord[mesh_pkg::x_cord_width-1:0];
  assign net_out_o.y_cord     = out_aligned.y_cord[mesh_pkg::y_cord_width-1:0];
  assign net_out_o.src_x_cord = my_x_i;
  assign net_out_o.src_y_cord = my_y_i;
  assign net_out_o.op         = mesh_pkg::mesh_op_e'(out_aligned.op);
  assign net_out_o.reg_id     = out_aligned.reg_id[mesh_pkg::reg_id_width-1:0];
  assign net_out_o.addr       = out_aligned.addr[mesh_pkg::addr_width-1:0];
  assign net_out_o.data       = out_aligned.data;

  assign net_out_valid_o = out_pkt_valid & has_credit;
  assign out_pkt_ready   = net_out_ready_i & has_credit;

  out_credit_counter u_credits (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .send_i         (net_out_valid_o & net_out_ready_i),
    .return_i       (net_ret_valid_i & net_ret_ready_o),
    .has_credit_o   (has_credit),
    .credits_used_o (credits_used_o)
  );

  // ------------------------------
  // Return to host
  // ------------------------------
  assign ret_aligned.padding  = '0;
  assign ret_aligned.data     = 32'(net_ret_i.data);
  assign ret_aligned.reg_id   = 8'(net_ret_i.reg_id);
  assign ret_aligned.pkt_type = net_ret_i.pkt_type;
  assign ret_aligned.y_cord   = 8'(my_y_i);
  assign ret_aligned.x_cord   = 8'(my_x_i);

  word_serializer u_ret_ser (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .pkt_i        (ret_aligned),
    .pkt_valid_i  (net_ret_valid_i),
    .pkt_ready_o  (net_ret_ready_o),
    .word_o       (host_rsp_word_o),
    .word_valid_o (host_rsp_valid_o),
    .word_ready_i (host_rsp_ready_i)
  );

  // ------------------------------
  // Inbound request
  // ------------------------------
  inbound_txn_fsm u_inbound (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .net_in_i         (net_in_i),
    .net_in_valid_i   (net_in_valid_i),
    .net_in_ready_o   (net_in_ready_o),
    .host_pkt_o       (in_req),
    .host_pkt_valid_o (in_pkt_valid),
    .host_pkt_ready_i (in_pkt_ready),
    .rd_pkt_i         (rd_data),
    .rd_pkt_valid_i   (rd_pkt_valid),
    .rd_pkt_ready_o   (rd_pkt_ready),
    .net_ack_o        (net_ack_o),
    .net_ack_valid_o  (net_ack_valid_o),
    .net_ack_ready_i  (net_ack_ready_i)
  );

  // Widen with zero fill, destination shows this tile
  assign in_aligned.padding    = '0;
  assign in_aligned.data       = 32'(in_req.data);
  assign in_aligned.addr       = 32'(in_req.addr);
  assign in_aligned.reg_id     = 8'(in_req.reg_id);
  assign in_aligned.op         = in_req.op;
  assign in_aligned.src_y_cord = 8'(in_req.src_y_cord);
  assign in_aligned.src_x_cord = 8'(in_req.src_x_cord);
  assign in_aligned.y_cord     = 8'(my_y_i);
  assign in_aligned.x_cord     = 8'(my_x_i);

  word_serializer u_in_ser (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .pkt_i        (in_aligned),
    .pkt_valid_i  (in_pkt_valid),
    .pkt_ready_o  (in_pkt_ready),
    .word_o       (host_in_req_word_o),
    .word_valid_o (host_in_req_valid_o),
    .word_ready_i (host_in_req_ready_i)
  );

  // Host read data for loads, only the data field matters
  word_deserializer u_rd_deser (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .word_i       (host_in_rsp_word_i),
    .word_valid_i (host_in_rsp_valid_i),
    .word_ready_o (host_in_rsp_ready_o),
    .pkt_o        (rd_aligned),
    .pkt_valid_o  (rd_pkt_valid),
    .pkt_ready_i  (rd_pkt_ready)
  );

  assign rd_data = rd_aligned.data[mesh_pkg::data_width-1:0];

endmodule

`default_nettype wire

// File: src/host_pkg.sv
// Host side packet layout; every field sits on a byte boundary and packets are four 32-bit words
`default_nettype none

package host_pkg;

  // ------------------------------
  // Host word stream
  // ------------------------------
  localparam int host_word_width  = 32;
  localparam int words_per_packet = 4;
  localparam int aligned_width    = host_word_width * words_per_packet;

  // Request packet, last member sits in the low bits
  typedef struct packed {
    logic [15:0] padding;
    logic [31:0] data;
    logic [31:0] addr;
    logic [7:0]  reg_id;
    logic [7:0]  op;
    logic [7:0]  src_y_cord;
    logic [7:0]  src_x_cord;
    logic [7:0]  y_cord;
    logic [7:0]  x_cord;
  } aligned_req_s;

  // Response packet, same byte ordering as the request
  typedef struct packed {
    logic [63:0] padding;
    logic [31:0] data;
    logic [7:0]  reg_id;
    logic [7:0]  pkt_type;
    logic [7:0]  y_cord;
    logic [7:0]  x_cord;
  } aligned_rsp_s;

  // Word 0 carries the coordinates, word 3 the padding
  // Both structs must fill exactly one packet

endpackage

`default_nettype wire

// File: src/inbound_txn_fsm.sv
// One inbound request at a time; a load blocks new requests until the host returns read data
`timescale 1ns/10ps
`default_nettype none

module inbound_txn_fsm (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  mesh_pkg::mesh_req_s             net_in_i,
  input  logic                            net_in_valid_i,
  output logic                            net_in_ready_o,
  output mesh_pkg::mesh_req_s             host_pkt_o,
  output logic                            host_pkt_valid_o,
  input  logic                            host_pkt_ready_i,
  input  logic [mesh_pkg::data_width-1:0] rd_pkt_i,
  input  logic                            rd_pkt_valid_i,
  output logic                            rd_pkt_ready_o,
  output mesh_pkg::mesh_ret_s             net_ack_o,
  output logic                            net_ack_valid_o,
  input  logic                            net_ack_ready_i
);

  typedef enum logic [1:0] {
    st_idle,
    st_offer,
    st_wait_read,
    st_ack
  } inbound_state_e;

  inbound_state_e state_q;
  inbound_state_e state_d;
  mesh_pkg::mesh_req_s req_q;
  logic [mesh_pkg::data_width-1:0] data_q;
  logic is_store;

  assign is_store = (req_q.op == mesh_pkg::op_store);

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (net_in_valid_i) begin
          state_d = st_offer;
        end
      end
      st_offer: begin
        if (host_pkt_ready_i) begin
          // Stores need no host reply
          state_d = is_store ? st_ack : st_wait_read;
        end
      end
      st_wait_read: begin
        if (rd_pkt_valid_i) begin
          state_d = st_ack;
        end
      end
      st_ack: begin
        if (net_ack_ready_i) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Captured request and read data
  always_ff @(posedge clk_i) begin
    if (state_q == st_idle && net_in_valid_i) begin
      req_q  <= net_in_i;
      data_q <= '0;
    end else if (state_q == st_wait_read && rd_pkt_valid_i) begin
      data_q <= rd_pkt_i;
    end
  end

  // ------------------------------
  // Outputs
  // ------------------------------
  assign net_in_ready_o   = (state_q == st_idle);
  assign host_pkt_o       = req_q;
  assign host_pkt_valid_o = (state_q == st_offer);
  assign rd_pkt_ready_o   = (state_q == st_wait_read);
  assign net_ack_valid_o  = (state_q == st_ack);

  always_comb begin
    if (is_store) begin
      net_ack_o.pkt_type = mesh_pkg::ret_store;
    end else begin
      net_ack_o.pkt_type = mesh_pkg::ret_load;
    end
    net_ack_o.reg_id = req_q.reg_id;
    // Zero for stores, cleared at capture
    net_ack_o.data   = data_q;
  end

endmodule

`default_nettype wire

// File: src/mesh_pkg.sv
// Mesh packet layout for a single tile; widths are fixed and not meant to be overridden
`default_nettype none

package mesh_pkg;

  // ------------------------------
  // Field widths
  // ------------------------------
  localparam int x_cord_width = 4;
  localparam int y_cord_width = 4;
  // Word address, not byte address
  localparam int addr_width   = 20;
  localparam int data_width   = 32;
  // Byte mask on stores, destination register on loads
  localparam int reg_id_width = 5;

  // Outstanding request accounting
  localparam int credit_width = 3;
  localparam logic [credit_width-1:0] max_out_credits = credit_width'(4);

  // ------------------------------
  // Encodings
  // ------------------------------
  typedef enum logic [7:0] {
    op_load  = 8'd0,
    op_store = 8'd1
  } mesh_op_e;

  typedef enum logic [7:0] {
    ret_load  = 8'd0,
    ret_store = 8'd1
  } return_type_e;

  // ------------------------------
  // Packets
  // ------------------------------
  typedef struct packed {
    logic [x_cord_width-1:0] x_cord;
    logic [y_cord_width-1:0] y_cord;
    logic [x_cord_width-1:0] src_x_cord;
    logic [y_cord_width-1:0] src_y_cord;
    mesh_op_e                op;
    logic [reg_id_width-1:0] reg_id;
    logic [addr_width-1:0]   addr;
    logic [data_width-1:0]   data;
  } mesh_req_s;

  typedef struct packed {
    return_type_e            pkt_type;
    logic [reg_id_width-1:0] reg_id;
    logic [data_width-1:0]   data;
  } mesh_ret_s;

endpackage

`default_nettype wire

// File: src/out_credit_counter.sv
// Caller must not send without has_credit_o; a return at zero count is ignored
`timescale 1ns/10ps
`default_nettype none

module out_credit_counter (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              send_i,
  input  logic                              return_i,
  output logic                              has_credit_o,
  output logic [mesh_pkg::credit_width-1:0] credits_used_o
);

  logic [mesh_pkg::credit_width-1:0] used_q;
  logic inc;
  logic dec;

  // Send and return together leave the count alone
  assign inc = send_i & ~return_i;
  assign dec = return_i & ~send_i & (used_q != '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      used_q <= '0;
    end else if (inc) begin
      used_q <= used_q + 1'b1;
    end else if (dec) begin
      used_q <= used_q - 1'b1;
    end
  end

  assign has_credit_o   = (used_q < mesh_pkg::max_out_credits);
  assign credits_used_o = used_q;

endmodule

`default_nettype wire

// File: src/word_deserializer.sv
// Holds one packet only; word side stalls until the packet leaves, word 0 lands in the low bits
`timescale 1ns/10ps
`default_nettype none

module word_deserializer (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic [host_pkg::host_word_width-1:0] word_i,
  input  logic                                word_valid_i,
  output logic                                word_ready_o,
  output logic [host_pkg::aligned_width-1:0]   pkt_o,
  output logic                                pkt_valid_o,
  input  logic                                pkt_ready_i
);

  logic [host_pkg::words_per_packet-1:0][host_pkg::host_word_width-1:0] words_q;
  logic [$clog2(host_pkg::words_per_packet)-1:0] fill_q;
  logic full_q;
  logic word_xfer;
  logic pkt_xfer;

  // A leaving packet frees room for the next first word
  assign word_ready_o = ~full_q | pkt_ready_i;
  assign word_xfer    = word_valid_i & word_ready_o;
  assign pkt_xfer     = full_q & pkt_ready_i;

  // Word storage
  always_ff @(posedge clk_i) begin
    if (word_xfer) begin
      words_q[fill_q] <= word_i;
    end
  end

  // Fill count and packet flag
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      fill_q <= '0;
      full_q <= 1'b0;
    end else begin
      if (word_xfer) begin
        fill_q <= fill_q + 1'b1;
      end
      // Count wraps on the last word
      if (word_xfer && (&fill_q)) begin
        full_q <= 1'b1;
      end else if (pkt_xfer) begin
        full_q <= 1'b0;
      end
    end
  end

  assign pkt_o       = words_q;
  assign pkt_valid_o = full_q;

endmodule

`default_nettype wire

// File: src/word_serializer.sv
// One packet deep; word 0 goes out the cycle after the load, no bubble between packets
`timescale 1ns/10ps
`default_nettype none

module word_serializer (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic [host_pkg::aligned_width-1:0]   pkt_i,
  input  logic                                pkt_valid_i,
  output logic                                pkt_ready_o,
  output logic [host_pkg::host_word_width-1:0] word_o,
  output logic                                word_valid_o,
  input  logic                                word_ready_i
);

  logic [host_pkg::words_per_packet-1:0][host_pkg::host_word_width-1:0] hold_q;
  logic [$clog2(host_pkg::words_per_packet)-1:0] idx_q;
  logic busy_q;
  logic word_xfer;
  logic last_word;
  logic load;

  assign last_word = &idx_q;
  assign word_xfer = busy_q & word_ready_i;

  // Free when empty or when the final word is leaving
  assign pkt_ready_o = ~busy_q | (word_xfer & last_word);
  assign load        = pkt_valid_i & pkt_ready_o;

  // Holding register
  always_ff @(posedge clk_i) begin
    if (load) begin
      hold_q <= pkt_i;
    end
  end

  // Word index and occupancy
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      idx_q  <= '0;
      busy_q <= 1'b0;
    end else if (load) begin
      idx_q  <= '0;
      busy_q <= 1'b1;
    end else if (word_xfer) begin
      idx_q <= idx_q + 1'b1;
      if (last_word) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Low word first
  assign word_o       = hold_q[idx_q];
  assign word_valid_o = busy_q;

endmodule

`default_nettype wire

// File: test/host_bridge_checker.sv
// Bound into host_bridge_top; rules hold only while reset is released
`timescale 1ns/10ps
`default_nettype none

module host_bridge_checker (
  input logic                              clk_i,
  input logic                              rst_n_i,
  input mesh_pkg::mesh_req_s               net_out_o,
  input logic                              net_out_valid_o,
  input logic                              net_out_ready_i,
  input logic [31:0]                       host_rsp_word_o,
  input logic                              host_rsp_valid_o,
  input logic                              host_rsp_ready_i,
  input logic [31:0]                       host_in_req_word_o,
  input logic                              host_in_req_valid_o,
  input logic                              host_in_req_ready_i,
  input logic                              net_in_ready_o,
  input logic                              net_ack_valid_o,
  input logic [mesh_pkg::credit_width-1:0] credits_used_o
);

  credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credits_used_o <= mesh_pkg::max_out_credits)
    else $error("credit count above limit");

  // Held requests must not change
  net_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    net_out_valid_o && !net_out_ready_i |=> net_out_valid_o && $stable(net_out_o))
    else $error("net_out changed while stalled");

  rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_rsp_valid_o && !host_rsp_ready_i |=> host_rsp_valid_o && $stable(host_rsp_word_o))
    else $error("host_rsp changed while stalled");

  in_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_in_req_valid_o && !host_in_req_ready_i |=>
      host_in_req_valid_o && $stable(host_in_req_word_o))
    else $error("host_in_req changed while stalled");

  ack_vs_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(net_ack_valid_o && net_in_ready_o))
    else $error("acknowledge raised while idle");

endmodule

`default_nettype wire

// File: test/host_bridge_tb.sv
// Directed tests for the tile host bridge at tile (3,5); mesh and host are modeled inline
`timescale 1ns/10ps
`default_nettype none

module host_bridge_tb;

  localparam int num_tests    = 6;
  localparam int test_cycles  = 400;
  localparam int clk_period   = 4;
  localparam int wait_limit   = 400;

  logic clk_i;
  logic rst_n_i;
  logic [31:0] host_req_word_i;
  logic host_req_valid_i;
  logic host_req_ready_o;
  logic [31:0] host_rsp_word_o;
  logic host_rsp_valid_o;
  logic host_rsp_ready_i;
  logic [31:0] host_in_req_word_o;
  logic host_in_req_valid_o;
  logic host_in_req_ready_i;
  logic [31:0] host_in_rsp_word_i;
  logic host_in_rsp_valid_i;
  logic host_in_rsp_ready_o;
  mesh_pkg::mesh_req_s net_out_o;
  logic net_out_valid_o;
  logic net_out_ready_i;
  mesh_pkg::mesh_ret_s net_ret_i;
  logic net_ret_valid_i;
  logic net_ret_ready_o;
  mesh_pkg::mesh_req_s net_in_i;
  logic net_in_valid_i;
  logic net_in_ready_o;
  mesh_pkg::mesh_ret_s net_ack_o;
  logic net_ack_valid_o;
  logic net_ack_ready_i;
  logic [mesh_pkg::credit_width-1:0] credits_used_o;

  int errors;
  int checks;
  integer seed;
  logic toggle_en;
  logic saw_ret_stall;

  // Observed transfers
  mesh_pkg::mesh_req_s out_q[$];
  logic [31:0] rsp_q[$];
  logic [31:0] inw_q[$];
  mesh_pkg::mesh_ret_s ack_q[$];
  time accept_t[$];
  time ack_t;

  host_bridge_top dut0 (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .my_x_i (4'd3), .my_y_i (4'd5),
    .host_req_word_i (host_req_word_i), .host_req_valid_i (host_req_valid_i),
    .host_req_ready_o (host_req_ready_o),
    .host_rsp_word_o (host_rsp_word_o), .host_rsp_valid_o (host_rsp_valid_o),
    .host_rsp_ready_i (host_rsp_ready_i),
    .host_in_req_word_o (host_in_req_word_o), .host_in_req_valid_o (host_in_req_valid_o),
    .host_in_req_ready_i (host_in_req_ready_i),
    .host_in_rsp_word_i (host_in_rsp_word_i), .host_in_rsp_valid_i (host_in_rsp_valid_i),
    .host_in_rsp_ready_o (host_in_rsp_ready_o),
    .net_out_o (net_out_o), .net_out_valid_o (net_out_valid_o),
    .net_out_ready_i (net_out_ready_i),
    .net_ret_i (net_ret_i), .net_ret_valid_i (net_ret_valid_i),
    .net_ret_ready_o (net_ret_ready_o),
    .net_in_i (net_in_i), .net_in_valid_i (net_in_valid_i), .net_in_ready_o (net_in_ready_o),
    .net_ack_o (net_ack_o), .net_ack_valid_o (net_ack_valid_o),
    .net_ack_ready_i (net_ack_ready_i),
    .credits_used_o (credits_used_o)
  );

  bind host_bridge_top host_bridge_checker u_checker (.*);

  always #(clk_period / 2) clk_i = ~clk_i;

  // ------------------------------
  // Monitors, sampled after the falling edge drives settle
  // ------------------------------
  always @(negedge clk_i) begin
    #1;
    if (rst_n_i) begin
      if (net_out_valid_o && net_out_ready_i) out_q.push_back(net_out_o);
      if (host_rsp_valid_o && host_rsp_ready_i) rsp_q.push_back(host_rsp_word_o);
      if (host_in_req_valid_o && host_in_req_ready_i) inw_q.push_back(host_in_req_word_o);
      if (net_in_valid_i && net_in_ready_o) accept_t.push_back($time);
      if (net_ack_valid_o && net_ack_ready_i) begin
        ack_q.push_back(net_ack_o);
        ack_t = $time;
      end
      if (net_ret_valid_i && !net_ret_ready_o) saw_ret_stall = 1'b1;
    end
  end

  // Random host back-pressure on the response stream
  always @(negedge clk_i) begin
    if (toggle_en) begin
      host_rsp_ready_i = $random(seed) & 1;
    end
  end

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      $display("** Error %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic int level(input int sel);
    case (sel)
      0: return out_q.size();
      1: return rsp_q.size();
      2: return inw_q.size();
      3: return ack_q.size();
      default: return accept_t.size();
    endcase
  endfunction

  // Waits until a monitor queue holds n entries
  task automatic wait_for(input int sel, input int n, input string what);
    int k;
    for (k = 0; k < wait_limit; k++) begin
      if (level(sel) >= n) return;
      @(negedge clk_i);
      #1;
    end
    $display("Timed out waiting for %s", what);
    errors++;
  endtask

  task automatic send_req_words(input host_pkg::aligned_req_s p);
    int i;
    for (i = 0; i < 4; i++) begin
      @(negedge clk_i);
      host_req_valid_i = 1'b1;
      host_req_word_i  = p[32*i +: 32];
      #1;
      while (!host_req_ready_o) begin
        @(negedge clk_i);
        #1;
      end
    end
    @(negedge clk_i);
    host_req_valid_i = 1'b0;
  endtask

  task automatic send_rd_words(input host_pkg::aligned_req_s p);
    int i;
    for (i = 0; i < 4; i++) begin
      @(negedge clk_i);
      host_in_rsp_valid_i = 1'b1;
      host_in_rsp_word_i  = p[32*i +: 32];
      #1;
      while (!host_in_rsp_ready_o) begin
        @(negedge clk_i);
        #1;
      end
    end
    @(negedge clk_i);
    host_in_rsp_valid_i = 1'b0;
  endtask

  task automatic send_net_ret(input mesh_pkg::mesh_ret_s r);
    @(negedge clk_i);
    net_ret_valid_i = 1'b1;
    net_ret_i       = r;
    #1;
    while (!net_ret_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    net_ret_valid_i = 1'b0;
  endtask

  task automatic send_net_in(input mesh_pkg::mesh_req_s r);
    @(negedge clk_i);
    net_in_valid_i = 1'b1;
    net_in_i       = r;
    #1;
    while (!net_in_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    net_in_valid_i = 1'b0;
  endtask

  // Mesh returns n credits, responses are drained and dropped
  task automatic give_returns(input int n);
    mesh_pkg::mesh_ret_s r;
    int i;
    r = '0;
    for (i = 0; i < n; i++) send_net_ret(r);
    wait_for(1, 4 * n, "drained host_rsp words");
    rsp_q.delete();
  endtask

  function automatic host_pkg::aligned_req_s make_req(input logic [7:0] op, input int tag);
    host_pkg::aligned_req_s p;
    p = '0;
    p.x_cord     = 8'(tag % 16);
    p.y_cord     = 8'd7;
    p.src_x_cord = 8'hAA;
    p.src_y_cord = 8'hBB;
    p.op         = op;
    p.reg_id     = 8'h0f + 8'(tag);
    p.addr       = 32'hABC1_2345 + tag;
    p.data       = 32'hDEAD_BEEF ^ tag;
    return p;
  endfunction

  // Narrowing rule: keep low bits, source is (3,5)
  function automatic mesh_pkg::mesh_req_s expect_out(input host_pkg::aligned_req_s p);
    mesh_pkg::mesh_req_s m;
    m.x_cord     = p.x_cord[3:0];
    m.y_cord     = p.y_cord[3:0];
    m.src_x_cord = 4'd3;
    m.src_y_cord = 4'd5;
    m.op         = (p.op == 8'd1) ? mesh_pkg::op_store : mesh_pkg::op_load;
    m.reg_id     = p.reg_id[4:0];
    m.addr       = p.addr[19:0];
    m.data       = p.data;
    return m;
  endfunction

  function automatic logic [127:0] expect_rsp(input mesh_pkg::mesh_ret_s r);
    host_pkg::aligned_rsp_s a;
    a          = '0;
    a.x_cord   = 8'd3;
    a.y_cord   = 8'd5;
    a.pkt_type = {7'd0, r.pkt_type == mesh_pkg::ret_store};
    a.reg_id   = {3'd0, r.reg_id};
    a.data     = r.data;
    return a;
  endfunction

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic test_outbound();
    host_pkg::aligned_req_s st;
    host_pkg::aligned_req_s ld;
    int e0;
    e0 = errors;
    out_q.delete();
    st = make_req(8'd1, 2);
    ld = make_req(8'd0, 9);
    // Mesh stalls the first packet for a few cycles
    net_out_ready_i = 1'b0;
    send_req_words(st);
    repeat (3) @(negedge clk_i);
    check("net_out count while stalled", out_q.size(), 0);
    net_out_ready_i = 1'b1;
    send_req_words(ld);
    wait_for(0, 2, "two net_out packets");
    if (out_q.size() == 2) begin
      check("net_out_o", out_q[0], expect_out(st));
      check("net_out_o", out_q[1], expect_out(ld));
    end
    check("credits_used_o", credits_used_o, 2);
    give_returns(2);
    $display("test outbound: %0d errors", errors - e0);
  endtask

  task automatic test_credit_limit();
    int e0;
    int i;
    e0 = errors;
    out_q.delete();
    for (i = 0; i < 5; i++) send_req_words(make_req(8'd1, i));
    wait_for(0, 4, "four net_out packets");
    // Window in which a fifth packet must not appear
    repeat (20) @(negedge clk_i);
    #1;
    check("net_out count", out_q.size(), 4);
    check("credits_used_o", credits_used_o, 4);
    give_returns(1);
    wait_for(0, 5, "fifth net_out packet");
    repeat (2) @(negedge clk_i);
    #1;
    check("credits_used_o", credits_used_o, 4);
    if (out_q.size() == 5) check("net_out_o", out_q[4], expect_out(make_req(8'd1, 4)));
    give_returns(4);
    check("credits_used_o", credits_used_o, 0);
    $display("test credit_limit: %0d errors", errors - e0);
  endtask

  task automatic test_return();
    mesh_pkg::mesh_ret_s r;
    int e0;
    e0 = errors;
    out_q.delete();
    rsp_q.delete();
    send_req_words(make_req(8'd0, 1));
    wait_for(0, 1, "net_out packet");
    r.pkt_type = mesh_pkg::ret_load;
    r.reg_id   = 5'h13;
    r.data     = 32'h1234_5678;
    send_net_ret(r);
    wait_for(1, 4, "host_rsp words");
    if (rsp_q.size() == 4) begin
      check("host_rsp packet", {rsp_q[3], rsp_q[2], rsp_q[1], rsp_q[0]}, expect_rsp(r));
    end
    check("credits_used_o", credits_used_o, 0);
    rsp_q.delete();
    $display("test return: %0d errors", errors - e0);
  endtask

  task automatic test_inbound_store();
    mesh_pkg::mesh_req_s q;
    host_pkg::aligned_req_s a;
    int e0;
    e0 = errors;
    inw_q.delete();
    ack_q.delete();
    q = '{x_cord: 4'd3, y_cord: 4'd5, src_x_cord: 4'd1, src_y_cord: 4'd2,
          op: mesh_pkg::op_store, reg_id: 5'h0a, addr: 20'h5_4321, data: 32'hCAFE_F00D};
    a = '{padding: 16'd0, data: 32'hCAFE_F00D, addr: 32'h0005_4321, reg_id: 8'h0a,
          op: 8'd1, src_y_cord: 8'd2, src_x_cord: 8'd1, y_cord: 8'd5, x_cord: 8'd3};
    @(negedge clk_i);
    // Host holds off the inbound words at first
    host_in_req_ready_i = 1'b0;
    send_net_in(q);
    repeat (4) @(negedge clk_i);
    host_in_req_ready_i = 1'b1;
    wait_for(2, 4, "host_in_req words");
    wait_for(3, 1, "store acknowledge");
    if (inw_q.size() == 4) begin
      check("host_in_req packet", {inw_q[3], inw_q[2], inw_q[1], inw_q[0]}, a);
    end
    if (ack_q.size() == 1) begin
      check("net_ack_o", ack_q[0], {mesh_pkg::ret_store, 5'h0a, 32'h0});
    end
    inw_q.delete();
    ack_q.delete();
    $display("test inbound_store: %0d errors", errors - e0);
  endtask

  task automatic test_inbound_load();
    mesh_pkg::mesh_req_s q;
    mesh_pkg::mesh_req_s q2;
    host_pkg::aligned_req_s rd;
    int e0;
    e0 = errors;
    inw_q.delete();
    ack_q.delete();
    accept_t.delete();
    q = '{x_cord: 4'd3, y_cord: 4'd5, src_x_cord: 4'd6, src_y_cord: 4'd0,
          op: mesh_pkg::op_load, reg_id: 5'h1c, addr: 20'h0_0abc, data: 32'h0};
    q2 = q;
    q2.op = mesh_pkg::op_store;
    send_net_in(q);
    wait_for(2, 4, "host_in_req words");
    @(negedge clk_i);
    net_in_valid_i = 1'b1;
    net_in_i       = q2;
    repeat (10) @(negedge clk_i);
    #1;
    check("net_ack count before read", ack_q.size(), 0);
    check("net_in accepts before read", accept_t.size(), 1);
    rd = '0;
    rd.data = 32'h0BAD_F00D;
    send_rd_words(rd);
    wait_for(3, 1, "load acknowledge");
    if (ack_q.size() >= 1) begin
      check("net_ack_o", ack_q[0], {mesh_pkg::ret_load, 5'h1c, 32'h0BAD_F00D});
    end
    wait_for(4, 2, "second net_in accept");
    @(negedge clk_i);
    net_in_valid_i = 1'b0;
    if (accept_t.size() == 2 && accept_t[1] <= ack_t) begin
      $display("Second request was accepted before the load acknowledge");
      errors++;
    end
    wait_for(3, 2, "second acknowledge");
    inw_q.delete();
    ack_q.delete();
    $display("test inbound_load: %0d errors", errors - e0);
  endtask

  task automatic test_backpressure();
    mesh_pkg::mesh_ret_s r[3];
    logic [127:0] exp;
    int e0;
    int i;
    int w;
    e0 = errors;
    rsp_q.delete();
    saw_ret_stall = 1'b0;
    toggle_en = 1'b1;
    for (i = 0; i < 3; i++) begin
      r[i].pkt_type = (i % 2) ? mesh_pkg::ret_store : mesh_pkg::ret_load;
      r[i].reg_id   = 5'(i + 3);
      r[i].data     = $random(seed);
      send_net_ret(r[i]);
    end
    wait_for(1, 12, "twelve host_rsp words");
    toggle_en = 1'b0;
    @(negedge clk_i);
    host_rsp_ready_i = 1'b1;
    for (i = 0; i < 3; i++) begin
      exp = expect_rsp(r[i]);
      for (w = 0; w < 4; w++) begin
        if (rsp_q.size() > 4 * i + w) check("host_rsp_word_o", rsp_q[4*i+w], exp[32*w +: 32]);
      end
    end
    if (!saw_ret_stall) begin
      $display("net_ret_ready_o never dropped while the serializer was busy");
      errors++;
    end
    rsp_q.delete();
    $display("test backpressure: %0d errors", errors - e0);
  endtask

  // Watchdog
  initial begin
    #(num_tests * test_cycles * clk_period);
    $display("Run stopped by the watchdog");
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    seed = 32'h1b81_16ba;
    errors = 0;
    checks = 0;
    toggle_en = 1'b0;
    saw_ret_stall = 1'b0;
    ack_t = 0;
    host_req_word_i = '0;
    host_req_valid_i = 1'b0;
    host_rsp_ready_i = 1'b1;
    host_in_req_ready_i = 1'b1;
    host_in_rsp_word_i = '0;
    host_in_rsp_valid_i = 1'b0;
    net_out_ready_i = 1'b1;
    net_ret_i = '0;
    net_ret_valid_i = 1'b0;
    net_in_i = '0;
    net_in_valid_i = 1'b0;
    net_ack_ready_i = 1'b1;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    test_outbound();
    test_credit_limit();
    test_return();
    test_inbound_store();
    test_inbound_load();
    test_backpressure();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
